//--- traffic_pkg.sv
// Shared definitions for the memory traffic generator
// Widths, address map, run states, CSR word map and the LFSR step
// Modules import this inside their bodies

`default_nettype none

package traffic_pkg;

    // ====================
    // Widths
    // ====================

    localparam int MEM_ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int CNT_W = 32;
    localparam int CYCLES_W = 20;

    // Random region and the checked subset inside it
    localparam int REGION_W = 12;
    localparam int CHK_W = 8;
    localparam int CHK_LOW_W = 6;
    localparam int CHK_HIGH_W = CHK_W - CHK_LOW_W;
    localparam int CHK_MID_W = REGION_W - CHK_W;

    // Index bit split between reads and writes when conflicts are off
    localparam int CONFLICT_BIT = 2;

    // Expected-value FIFO
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AFULL = 12;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;

    // One clearing write per shadow entry
    localparam int CLEAR_CYCLES = 256;

    // ====================
    // LFSR seeds and taps
    // ====================

    localparam logic [31:0] RD_SEED = 32'h2721;
    localparam logic [31:0] WR_SEED = 32'h8520;
    localparam logic [31:0] DATA_SEED = 32'h1;

    // Taps 32, 22, 2 and 1
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    typedef enum logic [1:0]
    {
        IDLE,
        RUN,
        DONE,
        ERROR
    } run_state_t;

    // Word index on APB address bits [4:2]
    typedef enum logic [2:0]
    {
        CTRL = 3'd0,
        BASE = 3'd1,
        GEOM = 3'd2,
        STATUS = 3'd3,
        RD_CNT = 3'd4,
        WR_CNT = 3'd5,
        CHK_CNT = 3'd6
    } csr_reg_t;

    // One Galois step, shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] value);
        return (value >> 1) ^ (value[0] ? LFSR_POLY : 32'h0);
    endfunction

endpackage

`default_nettype wire

//--- chk_shadow_ram.sv
// Shadow copy of the checked memory words
// Clears every entry after reset before raising ready, then serves
// one write and one 1-cycle read per cycle with write-first forwarding

`timescale 1ns/1ps
`default_nettype none

module chk_shadow_ram
(
    input  logic clk,
    input  logic reset,
    input  logic wr_en,
    input  logic [traffic_pkg::CHK_W-1:0] wr_idx,
    input  logic [traffic_pkg::DATA_W-1:0] wr_data,
    input  logic [traffic_pkg::CHK_W-1:0] rd_idx,
    output logic [traffic_pkg::DATA_W-1:0] rd_data,
    output logic ready
);
    import traffic_pkg::*;

    logic [DATA_W-1:0] mem [CLEAR_CYCLES];
    logic [CHK_W-1:0] clr_idx;
    logic we;
    logic [CHK_W-1:0] widx;
    logic [DATA_W-1:0] wdata;

    // Clearing sweep owns the write port until ready
    assign we = wr_en || !ready;
    assign widx = ready ? wr_idx : clr_idx;
    assign wdata = ready ? wr_data : '0;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            clr_idx <= '0;
            ready <= 1'b0;
        end
        else if (!ready)
        begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == CHK_W'(CLEAR_CYCLES - 1))
            begin
                ready <= 1'b1;
            end
        end
    end

    // Same-cycle write to the read index returns the new word
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[widx] <= wdata;
        end
        if (we && (widx == rd_idx))
        begin
            rd_data <= wdata;
        end
        else
        begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

`default_nettype wire

//--- traffic_decode.sv
// CSR block of the traffic generator
// APB slave with zero wait states, run configuration, cycle budget
// and the run state machine; a CTRL write starts a new run

`timescale 1ns/1ps
`default_nettype none

module traffic_decode
(
    input  logic clk,
    input  logic reset,

    // APB slave
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [7:0] paddr,
    input  logic [traffic_pkg::DATA_W-1:0] pwdata,
    output logic [traffic_pkg::DATA_W-1:0] prdata,
    output logic pready,
    output logic pslverr,

    // Status from the result block
    input  logic run_error,
    input  logic [traffic_pkg::CNT_W-1:0] rd_cnt,
    input  logic [traffic_pkg::CNT_W-1:0] wr_cnt,
    input  logic [traffic_pkg::CNT_W-1:0] chk_cnt,
    input  logic chk_ready,

    // Run control
    output traffic_pkg::run_state_t run_state,
    output logic start_pulse,
    output logic cfg_reads,
    output logic cfg_writes,
    output logic cfg_checker,
    output logic cfg_conflicts,
    output logic [traffic_pkg::MEM_ADDR_W-1:0] base_addr
);
    import traffic_pkg::*;

    logic access;
    logic addr_hit;
    logic ctrl_wr;
    logic base_wr;
    csr_reg_t reg_sel;
    logic [CYCLES_W-1:0] cycles_rem;

    // No wait states and no error responses
    assign pready = 1'b1;
    assign pslverr = 1'b0;

    // Word aligned, only the low 32 bytes decode
    assign access = psel && penable;
    assign addr_hit = (paddr[7:5] == 3'd0) && (paddr[1:0] == 2'd0);
    assign reg_sel = csr_reg_t'(paddr[4:2]);
    assign ctrl_wr = access && pwrite && addr_hit && (reg_sel == CTRL);
    assign base_wr = access && pwrite && addr_hit && (reg_sel == BASE);

    // ====================
    // Configuration
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            start_pulse <= 1'b0;
            cfg_reads <= 1'b0;
            cfg_writes <= 1'b0;
            cfg_checker <= 1'b0;
            cfg_conflicts <= 1'b0;
            base_addr <= '0;
        end
        else
        begin
            start_pulse <= ctrl_wr;
            // Bit 4 is reserved
            if (ctrl_wr)
            begin
                cfg_reads <= pwdata[0];
                cfg_writes <= pwdata[1];
                cfg_checker <= pwdata[2];
                cfg_conflicts <= pwdata[3];
            end
            if (base_wr)
            begin
                base_addr <= pwdata[MEM_ADDR_W-1:0];
            end
        end
    end

    // Budget loads with CTRL and counts down only while running
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cycles_rem <= '0;
        end
        else if (ctrl_wr)
        begin
            cycles_rem <= pwdata[DATA_W-1 -: CYCLES_W];
        end
        else if ((run_state == RUN) && (cycles_rem != '0))
        begin
            cycles_rem <= cycles_rem - 1'b1;
        end
    end

    // ====================
    // Run state machine
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            run_state <= IDLE;
        end
        else if (start_pulse)
        begin
            // A new run restarts from any state
            run_state <= RUN;
        end
        else if (run_state == RUN)
        begin
            // Mismatch wins over an expiring budget
            if (run_error)
            begin
                run_state <= ERROR;
            end
            else if (cycles_rem == '0)
            begin
                run_state <= DONE;
            end
        end
    end

    // Read data only during a read access phase
    always_comb
    begin
        prdata = '0;
        if (access && !pwrite && addr_hit)
        begin
            case (reg_sel)
                CTRL:    prdata = {cycles_rem, 8'd0, cfg_conflicts, cfg_checker,
                                   cfg_writes, cfg_reads};
                BASE:    prdata = DATA_W'(base_addr);
                GEOM:    prdata = {16'd0, 8'(CHK_W), 8'(REGION_W)};
                STATUS:  prdata = {29'd0, chk_ready, run_state};
                RD_CNT:  prdata = rd_cnt;
                WR_CNT:  prdata = wr_cnt;
                CHK_CNT: prdata = chk_cnt;
                default: prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- traffic_execute.sv
// Request generator of the traffic generator
// Three LFSRs give read and write indices and write data, requests
// are registered and issue only while running and not back-pressured

`timescale 1ns/1ps
`default_nettype none

module traffic_execute
(
    input  logic clk,
    input  logic reset,

    input  traffic_pkg::run_state_t run_state,
    input  logic start_pulse,
    input  logic cfg_reads,
    input  logic cfg_writes,
    input  logic cfg_conflicts,
    input  logic [traffic_pkg::MEM_ADDR_W-1:0] base_addr,
    input  logic chk_ready,
    input  logic mem_wr_full,
    input  logic mem_rd_full,

    // Memory requests
    output logic mem_wr_valid,
    output logic [traffic_pkg::MEM_ADDR_W-1:0] mem_wr_addr,
    output logic [traffic_pkg::DATA_W-1:0] mem_wr_data,
    output logic mem_rd_valid,
    output logic [traffic_pkg::MEM_ADDR_W-1:0] mem_rd_addr,

    // Shadow RAM update and lookup
    output logic chk_wr_en,
    output logic [traffic_pkg::CHK_W-1:0] chk_wr_idx,
    output logic chk_rd_en,
    output logic [traffic_pkg::CHK_W-1:0] chk_rd_idx,
    output logic chk_rd_checked
);
    import traffic_pkg::*;

    logic [31:0] rd_lfsr;
    logic [31:0] wr_lfsr;
    logic [DATA_W-1:0] data_lfsr;
    logic [REGION_W-1:0] rd_idx;
    logic [REGION_W-1:0] wr_idx;
    logic rd_go;
    logic wr_go;

    // Checked only when the middle bits are all zero
    function automatic logic idx_checked(input logic [REGION_W-1:0] idx);
        return idx[CHK_LOW_W +: CHK_MID_W] == '0;
    endfunction

    // High bits followed by low bits
    function automatic logic [CHK_W-1:0] idx_to_chk(input logic [REGION_W-1:0] idx);
        return {idx[REGION_W-1 -: CHK_HIGH_W], idx[CHK_LOW_W-1:0]};
    endfunction

    // ====================
    // Random sources
    // ====================

    // Reseeded per run so every run replays the same stream
    always_ff @(posedge clk)
    begin
        if (reset || start_pulse)
        begin
            rd_lfsr <= RD_SEED;
            wr_lfsr <= WR_SEED;
            data_lfsr <= DATA_SEED;
        end
        else
        begin
            rd_lfsr <= lfsr_next(rd_lfsr);
            wr_lfsr <= lfsr_next(wr_lfsr);
            data_lfsr <= lfsr_next(data_lfsr);
        end
    end

    // Split read and write indices when conflicts are off
    always_comb
    begin
        rd_idx = rd_lfsr[REGION_W-1:0];
        wr_idx = wr_lfsr[REGION_W-1:0];
        if (!cfg_conflicts)
        begin
            rd_idx[CONFLICT_BIT] = 1'b0;
            wr_idx[CONFLICT_BIT] = 1'b1;
        end
    end

    // ====================
    // Request issue
    // ====================

    assign rd_go = (run_state == RUN) && cfg_reads && chk_ready && !mem_rd_full;
    assign wr_go = (run_state == RUN) && cfg_writes && chk_ready && !mem_wr_full;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mem_rd_valid <= 1'b0;
            mem_wr_valid <= 1'b0;
            chk_wr_en <= 1'b0;
        end
        else
        begin
            mem_rd_valid <= rd_go;
            mem_wr_valid <= wr_go;
            // Shadow copy only for checked writes
            chk_wr_en <= wr_go && idx_checked(wr_idx);
        end
    end

    // Every issued read looks up the shadow RAM
    assign chk_rd_en = mem_rd_valid;

    // Address and data travel with the valids
    always_ff @(posedge clk)
    begin
        mem_rd_addr <= base_addr + MEM_ADDR_W'(rd_idx);
        mem_wr_addr <= base_addr + MEM_ADDR_W'(wr_idx);
        mem_wr_data <= data_lfsr;
        chk_rd_idx <= idx_to_chk(rd_idx);
        chk_rd_checked <= idx_checked(rd_idx);
        chk_wr_idx <= idx_to_chk(wr_idx);
    end

endmodule

`default_nettype wire

//--- traffic_result.sv
// Read checker and counters of the traffic generator
// Expected words wait in a small FIFO and meet responses in order,
// a checked mismatch while running raises run_error

`timescale 1ns/1ps
`default_nettype none

module traffic_result
(
    input  logic clk,
    input  logic reset,
    input  logic start_pulse,
    input  traffic_pkg::run_state_t run_state,
    input  logic cfg_checker,

    // Issued writes and their shadow copies
    input  logic mem_wr_valid,
    input  logic chk_wr_en,
    input  logic [traffic_pkg::CHK_W-1:0] chk_wr_idx,
    input  logic [traffic_pkg::DATA_W-1:0] mem_wr_data,

    // Issued reads
    input  logic chk_rd_en,
    input  logic [traffic_pkg::CHK_W-1:0] chk_rd_idx,
    input  logic chk_rd_checked,

    // Memory responses
    input  logic mem_rsp_valid,
    input  logic [traffic_pkg::DATA_W-1:0] mem_rsp_data,

    output logic chk_ready,
    output logic run_error,
    output logic [traffic_pkg::CNT_W-1:0] rd_cnt,
    output logic [traffic_pkg::CNT_W-1:0] wr_cnt,
    output logic [traffic_pkg::CNT_W-1:0] chk_cnt
);
    import traffic_pkg::*;

    logic ram_ready;
    logic [DATA_W-1:0] shadow_data;
    logic push_en;
    logic push_checked;
    logic pop_en;
    logic [DATA_W-1:0] fifo_data [FIFO_DEPTH];
    logic fifo_chk [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] fifo_count;
    logic head_checked;
    logic [DATA_W-1:0] head_data;
    logic mismatch;

    chk_shadow_ram u_shadow
    (
        .clk, .reset,
        .wr_en(chk_wr_en),
        .wr_idx(chk_wr_idx),
        .wr_data(mem_wr_data),
        .rd_idx(chk_rd_idx),
        .rd_data(shadow_data),
        .ready(ram_ready)
    );

    // Lookup result is ready one cycle after the read issue
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            push_en <= 1'b0;
        end
        else
        begin
            push_en <= chk_rd_en;
        end
        push_checked <= chk_rd_checked;
    end

    // ====================
    // Expected-value FIFO
    // ====================

    // Falls through when empty so a fast response meets its entry
    assign head_checked = (fifo_count == '0) ? push_checked : fifo_chk[rd_ptr];
    assign head_data = (fifo_count == '0) ? shadow_data : fifo_data[rd_ptr];
    assign pop_en = mem_rsp_valid && ((fifo_count != '0) || push_en);
    assign mismatch = pop_en && head_checked && (mem_rsp_data != head_data);

    always_ff @(posedge clk)
    begin
        if (push_en)
        begin
            fifo_data[wr_ptr] <= shadow_data;
            fifo_chk[wr_ptr] <= push_checked;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fifo_count <= '0;
            chk_ready <= 1'b0;
        end
        else
        begin
            wr_ptr <= wr_ptr + FIFO_PTR_W'(push_en);
            rd_ptr <= rd_ptr + FIFO_PTR_W'(pop_en);
            fifo_count <= fifo_count + FIFO_CNT_W'(push_en) - FIFO_CNT_W'(pop_en);
            // Leaves room for requests still in the pipeline
            chk_ready <= ram_ready && (fifo_count < FIFO_CNT_W'(FIFO_AFULL));
        end
    end

    // ====================
    // Error flag and counters
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset || start_pulse)
        begin
            run_error <= 1'b0;
            rd_cnt <= '0;
            wr_cnt <= '0;
            chk_cnt <= '0;
        end
        else
        begin
            if (mem_rsp_valid)
            begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            // Writes count at issue
            if (mem_wr_valid)
            begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (pop_en && head_checked)
            begin
                chk_cnt <= chk_cnt + 1'b1;
            end
            if (mismatch && cfg_checker && (run_state == RUN))
            begin
                run_error <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- traffic_top.sv
// Top level of the memory traffic generator
// The APB port programs a run, the memory ports drive an external
// word memory and take back its read responses

`timescale 1ns/1ps
`default_nettype none

module traffic_top
(
    input  logic clk,
    input  logic reset,

    // APB CSR port
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [7:0] paddr,
    input  logic [traffic_pkg::DATA_W-1:0] pwdata,
    output logic [traffic_pkg::DATA_W-1:0] prdata,
    output logic pready,
    output logic pslverr,

    // Memory request channels
    output logic mem_wr_valid,
    output logic [traffic_pkg::MEM_ADDR_W-1:0] mem_wr_addr,
    output logic [traffic_pkg::DATA_W-1:0] mem_wr_data,
    output logic mem_rd_valid,
    output logic [traffic_pkg::MEM_ADDR_W-1:0] mem_rd_addr,
    input  logic mem_wr_full,
    input  logic mem_rd_full,

    // Read responses, in order
    input  logic mem_rsp_valid,
    input  logic [traffic_pkg::DATA_W-1:0] mem_rsp_data
);
    import traffic_pkg::*;

    run_state_t run_state;
    logic start_pulse;
    logic cfg_reads;
    logic cfg_writes;
    logic cfg_checker;
    logic cfg_conflicts;
    logic [MEM_ADDR_W-1:0] base_addr;

    logic chk_ready;
    logic run_error;
    logic [CNT_W-1:0] rd_cnt;
    logic [CNT_W-1:0] wr_cnt;
    logic [CNT_W-1:0] chk_cnt;

    // Shadow write and lookup from execute to result
    logic chk_wr_en;
    logic [CHK_W-1:0] chk_wr_idx;
    logic chk_rd_en;
    logic [CHK_W-1:0] chk_rd_idx;
    logic chk_rd_checked;

    traffic_decode u_decode
    (
        .clk, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .run_error, .rd_cnt, .wr_cnt, .chk_cnt, .chk_ready,
        .run_state, .start_pulse,
        .cfg_reads, .cfg_writes, .cfg_checker, .cfg_conflicts,
        .base_addr
    );

    traffic_execute u_execute
    (
        .clk, .reset,
        .run_state, .start_pulse,
        .cfg_reads, .cfg_writes, .cfg_conflicts,
        .base_addr, .chk_ready, .mem_wr_full, .mem_rd_full,
        .mem_wr_valid, .mem_wr_addr, .mem_wr_data,
        .mem_rd_valid, .mem_rd_addr,
        .chk_wr_en, .chk_wr_idx,
        .chk_rd_en, .chk_rd_idx, .chk_rd_checked
    );

    traffic_result u_result
    (
        .clk, .reset,
        .start_pulse, .run_state, .cfg_checker,
        .mem_wr_valid, .chk_wr_en, .chk_wr_idx, .mem_wr_data,
        .chk_rd_en, .chk_rd_idx, .chk_rd_checked,
        .mem_rsp_valid, .mem_rsp_data,
        .chk_ready, .run_error, .rd_cnt, .wr_cnt, .chk_cnt
    );

endmodule

`default_nettype wire

//--- traffic_props.sv
// Concurrent assertions for the traffic generator top level
// Bound onto traffic_top from the testbench

`timescale 1ns/1ps
`default_nettype none

module traffic_props
(
    input wire logic clk,
    input wire logic reset,
    input wire logic chk_ready,
    input wire logic mem_wr_valid,
    input wire logic mem_rd_valid,
    input wire logic mem_wr_full,
    input wire logic mem_rd_full
);

    // Both request channels are quiet after reset
    assert property (@(posedge clk) reset |=> (!mem_wr_valid && !mem_rd_valid))
        else $error("request valid high right after reset");

    // A full channel gets no request in the next cycle
    assert property (@(posedge clk) disable iff (reset) mem_rd_full |=> !mem_rd_valid)
        else $error("read request issued while read channel full");

    assert property (@(posedge clk) disable iff (reset) mem_wr_full |=> !mem_wr_valid)
        else $error("write request issued while write channel full");

    // Checker not ready holds back both channels
    assert property (@(posedge clk) disable iff (reset)
        !chk_ready |=> (!mem_wr_valid && !mem_rd_valid))
        else $error("request issued while the checker was not ready");

endmodule

`default_nettype wire

//--- tb_traffic.sv
// Testbench for the memory traffic generator
// Programs runs over APB, models the word memory with random response
// latency and checks counters and run status against reference values

`timescale 1ns/1ps
`default_nettype none

module tb_traffic;
    import traffic_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam logic [15:0] BASE_ADDR = 16'h1000;
    localparam int BUDGET_WR = 400;
    localparam int BUDGET_MIX = 600;
    localparam int BUDGET_ERR = 600;
    localparam int BUDGET_BP = 800;
    localparam int BUDGET_RESTART = 200;
    localparam int WATCHDOG_CYCLES =
        BUDGET_WR + BUDGET_MIX + BUDGET_ERR + BUDGET_BP + BUDGET_RESTART + 2000;

    logic clk;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [7:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic mem_wr_valid;
    logic [15:0] mem_wr_addr;
    logic [31:0] mem_wr_data;
    logic mem_rd_valid;
    logic [15:0] mem_rd_addr;
    logic mem_wr_full;
    logic mem_rd_full;
    logic mem_rsp_valid = 1'b0;
    logic [31:0] mem_rsp_data = 32'h0;

    // Memory model state
    logic [31:0] mem_model [logic [15:0]];
    logic [31:0] rsp_data_q [$];
    logic rsp_chk_q [$];
    longint rsp_due_q [$];
    longint cycle_cnt = 0;
    longint last_due = 0;
    integer seed = 32'hab12;
    bit check_addr_map = 1'b0;
    bit corrupt_armed = 1'b0;
    int wr_seen = 0;
    int rsp_seen = 0;
    int rsp_checked_seen = 0;

    // Previous write of the run, for the data stream check
    bit wr_chain = 1'b0;
    logic [31:0] last_wr_data = 32'h0;
    longint last_wr_cycle = 0;

    int errors = 0;
    int checks = 0;

    traffic_top DUT (.*);

    bind traffic_top traffic_props u_props
    (
        .clk, .reset, .chk_ready,
        .mem_wr_valid, .mem_rd_valid, .mem_wr_full, .mem_rd_full
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Reference model
    // ====================

    // {checked, checked index} of a region offset
    function automatic logic [8:0] ref_map(input logic [31:0] value);
        logic [11:0] idx;
        idx = value[11:0];
        return {idx[9:6] == 4'd0, idx[11:10], idx[5:0]};
    endfunction

    // Unwritten words read as zero
    function automatic logic [31:0] ref_read(input logic [15:0] addr);
        if (mem_model.exists(addr))
            return mem_model[addr];
        return 32'h0;
    endfunction

    function automatic logic [7:0] reg_addr(input csr_reg_t r);
        return {3'b000, r, 2'b00};
    endfunction

    // Memory side, sampled on the edge and answered 2 ns later
    always @(posedge clk)
    begin
        int lat;
        longint due;
        logic [8:0] map;
        logic [15:0] offset;
        logic [31:0] data;
        logic [31:0] exp_data;
        logic chk;
        cycle_cnt++;
        if (!reset)
        begin
            // Write first so a same-cycle read sees the new word
            if (mem_wr_valid)
            begin
                mem_model[mem_wr_addr] = mem_wr_data;
                wr_seen++;
                offset = mem_wr_addr - BASE_ADDR;
                if (check_addr_map)
                begin
                    checks++;
                    assert ((offset < 16'd4096) && offset[2])
                    else
                    begin
                        $display("Write address %h lies outside the write region", mem_wr_addr);
                        errors++;
                    end
                end
                // Data LFSR steps once per cycle between two writes
                if (wr_chain)
                begin
                    exp_data = last_wr_data;
                    repeat (cycle_cnt - last_wr_cycle)
                        exp_data = lfsr_next(exp_data);
                    checks++;
                    assert (mem_wr_data === exp_data)
                    else
                    begin
                        $display("Error write_data expected %h actual %h",
                                 exp_data, mem_wr_data);
                        errors++;
                    end
                end
                wr_chain = 1'b1;
                last_wr_data = mem_wr_data;
                last_wr_cycle = cycle_cnt;
            end
            if (mem_rd_valid)
            begin
                offset = mem_rd_addr - BASE_ADDR;
                if (check_addr_map)
                begin
                    checks++;
                    assert ((offset < 16'd4096) && !offset[2])
                    else
                    begin
                        $display("Read address %h lies outside the read region", mem_rd_addr);
                        errors++;
                    end
                end
                lat = 1 + int'({$random(seed)} % 8);
                due = cycle_cnt + lat;
                if (due <= last_due)
                    due = last_due + 1;
                last_due = due;
                map = ref_map(32'(mem_rd_addr - BASE_ADDR));
                rsp_data_q.push_back(ref_read(mem_rd_addr));
                rsp_chk_q.push_back(map[8]);
                rsp_due_q.push_back(due);
            end
        end
        #2;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = 32'h0;
        if ((rsp_due_q.size() > 0) && (rsp_due_q[0] <= cycle_cnt))
        begin
            data = rsp_data_q.pop_front();
            chk = rsp_chk_q.pop_front();
            due = rsp_due_q.pop_front();
            // One flipped word on a checked read
            if (chk && corrupt_armed)
            begin
                data = ~data;
                corrupt_armed = 1'b0;
            end
            mem_rsp_valid = 1'b1;
            mem_rsp_data = data;
            rsp_seen++;
            if (chk)
                rsp_checked_seen++;
        end
    end

    // ====================
    // APB and run helpers
    // ====================

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        psel = 1'b1;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #2;
        penable = 1'b1;
        check_eq("apb_write_response", 32'h1, {30'd0, pslverr, pready});
        @(posedge clk);
        #2;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        #2;
        psel = 1'b1;
        pwrite = 1'b0;
        paddr = addr;
        @(posedge clk);
        #2;
        penable = 1'b1;
        #(CLK_PERIOD / 2);
        data = prdata;
        check_eq("apb_read_response", 32'h1, {30'd0, pslverr, pready});
        @(posedge clk);
        #2;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act)
        else
        begin
            $display("Error %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before)
            $display("Test %s: ok", name);
        else
            $display("Test %s: failed with %0d errors", name, errors - errors_before);
    endtask

    // Poll STATUS until the state matches or the poll limit runs out
    task automatic wait_state(input run_state_t state, input int polls, input bit leave);
        logic [31:0] status;
        int n;
        n = 0;
        apb_read(reg_addr(STATUS), status);
        while (((status[1:0] == state) == leave) && (n < polls))
        begin
            apb_read(reg_addr(STATUS), status);
            n++;
        end
        if ((status[1:0] == state) == leave)
        begin
            $display("Run state did not %s state %0d in time", leave ? "leave" : "reach", state);
            errors++;
        end
    endtask

    task automatic start_run(input int budget, input logic [4:0] bits);
        wr_seen = 0;
        rsp_seen = 0;
        rsp_checked_seen = 0;
        wr_chain = 1'b0;
        apb_write(reg_addr(CTRL), {20'(budget), 7'd0, bits});
        wait_state(RUN, 10, 1'b0);
    endtask

    // Run ends, then all responses come home
    task automatic finish_run(input int budget);
        int n;
        wait_state(RUN, budget / 3 + 20, 1'b1);
        n = 0;
        while ((rsp_due_q.size() > 0) && (n < 100))
        begin
            @(posedge clk);
            n++;
        end
        repeat (4) @(posedge clk);
        #2;
        if (rsp_due_q.size() > 0)
        begin
            $display("Read responses still pending after the run");
            errors++;
        end
    endtask

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        logic [31:0] rdata;
        int e0;
        bit rd_back;
        bit wr_back;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 8'h0;
        pwdata = 32'h0;
        mem_wr_full = 1'b0;
        mem_rd_full = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        e0 = errors;
        repeat (3)
        begin
            @(posedge clk);
            check_eq("reset_valids", 32'h0, {30'd0, mem_rd_valid, mem_wr_valid});
        end
        apb_read(reg_addr(GEOM), rdata);
        check_eq("geom", 32'h0000_080C, rdata);
        apb_write(reg_addr(BASE), {16'd0, BASE_ADDR});
        apb_read(reg_addr(BASE), rdata);
        check_eq("base", {16'd0, BASE_ADDR}, rdata);
        // Shadow clearing sweep
        repeat (150)
        begin
            apb_read(reg_addr(STATUS), rdata);
        end
        check_eq("chk_ready", 32'h1, {31'd0, rdata[2]});
        report_test("reset_and_csr", e0);

        e0 = errors;
        check_addr_map = 1'b1;
        start_run(BUDGET_WR, 5'b00010);
        finish_run(BUDGET_WR);
        check_addr_map = 1'b0;
        apb_read(reg_addr(STATUS), rdata);
        check_eq("write_only_state", 32'(DONE), {30'd0, rdata[1:0]});
        apb_read(reg_addr(WR_CNT), rdata);
        check_eq("write_only_wr_cnt", 32'(wr_seen), rdata);
        report_test("write_only", e0);

        e0 = errors;
        start_run(BUDGET_MIX, 5'b01111);
        finish_run(BUDGET_MIX);
        apb_read(reg_addr(STATUS), rdata);
        check_eq("mixed_state", 32'(DONE), {30'd0, rdata[1:0]});
        apb_read(reg_addr(RD_CNT), rdata);
        check_eq("mixed_rd_cnt", 32'(rsp_seen), rdata);
        apb_read(reg_addr(CHK_CNT), rdata);
        check_eq("mixed_chk_cnt", 32'(rsp_checked_seen), rdata);
        report_test("mixed_clean", e0);

        e0 = errors;
        corrupt_armed = 1'b1;
        start_run(BUDGET_ERR, 5'b00111);
        finish_run(BUDGET_ERR);
        if (corrupt_armed)
        begin
            $display("No checked read response came back to corrupt");
            errors++;
            corrupt_armed = 1'b0;
        end
        apb_read(reg_addr(STATUS), rdata);
        check_eq("corrupt_state", 32'(ERROR), {30'd0, rdata[1:0]});
        report_test("corrupt_response", e0);

        // Restart with no traffic so the cleared counters stay put
        e0 = errors;
        start_run(BUDGET_RESTART, 5'b00000);
        apb_read(reg_addr(STATUS), rdata);
        check_eq("restart_state", 32'(RUN), {30'd0, rdata[1:0]});
        apb_read(reg_addr(RD_CNT), rdata);
        check_eq("restart_rd_cnt", 32'h0, rdata);
        apb_read(reg_addr(WR_CNT), rdata);
        check_eq("restart_wr_cnt", 32'h0, rdata);
        apb_read(reg_addr(CHK_CNT), rdata);
        check_eq("restart_chk_cnt", 32'h0, rdata);
        finish_run(BUDGET_RESTART);
        apb_read(reg_addr(STATUS), rdata);
        check_eq("restart_done", 32'(DONE), {30'd0, rdata[1:0]});
        report_test("restart_after_error", e0);

        e0 = errors;
        check_addr_map = 1'b1;
        start_run(BUDGET_BP, 5'b00111);
        repeat (20) @(posedge clk);
        #2;
        mem_rd_full = 1'b1;
        mem_wr_full = 1'b1;
        @(posedge clk);
        repeat (30)
        begin
            @(posedge clk);
            check_eq("bp_valids", 32'h0, {30'd0, mem_rd_valid, mem_wr_valid});
        end
        #2;
        mem_rd_full = 1'b0;
        mem_wr_full = 1'b0;
        rd_back = 1'b0;
        wr_back = 1'b0;
        repeat (20)
        begin
            @(posedge clk);
            rd_back = rd_back | mem_rd_valid;
            wr_back = wr_back | mem_wr_valid;
        end
        check_eq("bp_resume", 32'h3, {30'd0, rd_back, wr_back});
        finish_run(BUDGET_BP);
        check_addr_map = 1'b0;
        apb_read(reg_addr(STATUS), rdata);
        check_eq("bp_state", 32'(DONE), {30'd0, rdata[1:0]});
        report_test("back_pressure", e0);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Simulation PASSED");
        end
        else
        begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Sum of the run budgets plus slack for polling and the sweep
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
traffic_pkg.sv
chk_shadow_ram.sv
traffic_decode.sv
traffic_execute.sv
traffic_result.sv
traffic_top.sv
traffic_props.sv
tb_traffic.sv

//--- run.sh
#!/bin/sh
# Build the traffic generator testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_traffic \
    -o tb_traffic_sim

./obj_dir/tb_traffic_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi
